// ==== design/invaders_macros.svh ====
`ifndef INVADERS_MACROS_SVH
`define INVADERS_MACROS_SVH

// playfield
`define FRAME_WIDTH 64
`define FRAME_HEIGHT 48

`define PIXEL_WIDTH 11
`define RGB_WIDTH 8
`define KEYCODE_WIDTH 9

`define PLAYER_Y 42
`define PLAYER_W 6
`define PLAYER_H 3
`define PLAYER_STEP 2

`define MONSTER_COUNT 6
`define MONSTER_INDEX_WIDTH $clog2(`MONSTER_COUNT)
`define MONSTER_W 4
`define MONSTER_H 3
`define MONSTER_PITCH 8 // left edge to left edge
`define MONSTER_Y 8
`define MONSTER_STEP 1

`define MISSILE_H 3
`define MISSILE_STEP 3

// colours are rrrgggbb
`define COLOR_PLAYER 8'h1C
`define COLOR_MISSILE 8'hFC
`define COLOR_MONSTER 8'hE3
`define COLOR_BORDER 8'hFF
`define COLOR_BACKGROUND 8'h02

// ps/2 set 2 codes
`define SC_EXTEND 8'hE0
`define SC_BREAK 8'hF0
`define SC_LEFT 8'h6B // extended
`define SC_RIGHT 8'h74 // extended
`define SC_FIRE 8'h29 // space bar

`endif

// ==== design/videoPkg.sv ====
`include "invaders_macros.svh"

package videoPkg;

    // raster coordinate, wide enough for a full size screen
    typedef logic [`PIXEL_WIDTH - 1:0] pixelT;

    typedef logic [`RGB_WIDTH - 1:0] rgbT; // 3-3-2 colour

endpackage : videoPkg

// ==== design/gamePkg.sv ====
`include "invaders_macros.svh"

package gamePkg;

    typedef logic [7:0] scanByteT; // one byte from the keyboard

    // bit 8 set for codes that came after an E0 prefix
    typedef logic [`KEYCODE_WIDTH - 1:0] keyCodeT;

    typedef enum logic [1:0] {
        decodeIdle,
        decodeExtended, // E0 seen
        decodeRelease, // F0 seen
        decodeExtendedRelease // E0 F0 seen
    } decodeStateT;

    typedef logic [`MONSTER_COUNT - 1:0] monsterMaskT; // one flag per monster

    typedef logic [7:0] scoreT;

endpackage : gamePkg

// ==== design/drawIf.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

interface drawIf;

    logic playerDraw;
    videoPkg::rgbT playerRgb;
    logic missileDraw;
    videoPkg::rgbT missileRgb;
    logic monsterDraw;
    videoPkg::rgbT monsterRgb;
    logic [`MONSTER_INDEX_WIDTH - 1:0] monsterIndex; // monster under the current pixel

    modport object (
        output playerDraw, playerRgb,
        output missileDraw, missileRgb,
        output monsterDraw, monsterRgb, monsterIndex
    );

    modport mixer (
        input playerDraw, playerRgb,
        input missileDraw, missileRgb,
        input monsterDraw, monsterRgb, monsterIndex
    );

endinterface

// ==== design/scanDecoder.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module scanDecoder (
    input logic clk,
    input logic reset,
    input logic scanValid,
    input gamePkg::scanByteT scanByte,
    output logic leftHeld,
    output logic rightHeld,
    output logic fireHeld
);

    localparam gamePkg::keyCodeT KEY_LEFT = {1'b1, `SC_LEFT};
    localparam gamePkg::keyCodeT KEY_RIGHT = {1'b1, `SC_RIGHT};
    localparam gamePkg::keyCodeT KEY_FIRE = {1'b0, `SC_FIRE};

    gamePkg::decodeStateT state;
    gamePkg::decodeStateT nextState;
    gamePkg::keyCodeT keyCode;
    logic make;
    logic brake;

    always_comb begin
        nextState = state;
        keyCode = {1'b0, scanByte};
        make = 1'b0;
        brake = 1'b0;
        if (scanValid) begin
            nextState = gamePkg::decodeIdle; // any code byte ends the sequence
            case (state)
                gamePkg::decodeIdle: begin
                    if (scanByte == `SC_EXTEND) begin
                        nextState = gamePkg::decodeExtended;
                    end else if (scanByte == `SC_BREAK) begin
                        nextState = gamePkg::decodeRelease;
                    end else begin
                        make = 1'b1;
                    end
                end
                gamePkg::decodeExtended: begin
                    keyCode = {1'b1, scanByte};
                    if (scanByte == `SC_BREAK) begin
                        nextState = gamePkg::decodeExtendedRelease;
                    end else begin
                        make = 1'b1;
                    end
                end
                gamePkg::decodeRelease: begin
                    brake = 1'b1;
                end
                default: begin // extended release
                    keyCode = {1'b1, scanByte};
                    brake = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= gamePkg::decodeIdle;
            leftHeld <= 1'b0;
            rightHeld <= 1'b0;
            fireHeld <= 1'b0;
        end else begin
            state <= nextState;
            if (make || brake) begin
                if (keyCode == KEY_LEFT) leftHeld <= make; // brake clears
                if (keyCode == KEY_RIGHT) rightHeld <= make;
                if (keyCode == KEY_FIRE) fireHeld <= make;
            end
        end
    end

    scanValidKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(scanValid))
        else $error("scanValid is unknown");

endmodule

// ==== design/hitDetector.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module hitDetector (
    input logic clk,
    input logic reset,
    input logic lastPixel,
    drawIf.mixer obj,
    output gamePkg::monsterMaskT hitMask
);

    gamePkg::monsterMaskT pixelHit;
    logic overlap;

    assign overlap = obj.missileDraw && obj.monsterDraw;

    always_comb begin
        pixelHit = '0;
        if (overlap) begin
            pixelHit[obj.monsterIndex] = 1'b1;
        end
    end

    // the mask is read by gameObjects on the same edge that clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            hitMask <= '0;
        end else if (lastPixel) begin
            hitMask <= '0;
        end else begin
            hitMask <= hitMask | pixelHit;
        end
    end

    // an overlap names one of the monsters so its hit bit lands in the mask
    hitIndexInRange: assert property (@(posedge clk) disable iff (reset)
        overlap |-> (obj.monsterIndex < `MONSTER_COUNT))
        else $error("missile hit on a monster index outside the row");

endmodule

// ==== design/gameObjects.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module gameObjects (
    input logic clk,
    input logic reset,
    input logic leftHeld,
    input logic rightHeld,
    input logic fireHeld,
    input logic lastPixel,
    input videoPkg::pixelT scanX,
    input videoPkg::pixelT scanY,
    input gamePkg::monsterMaskT hitMask,
    drawIf.object obj,
    output gamePkg::scoreT score
);

    localparam videoPkg::pixelT PLAYER_START = videoPkg::pixelT'((`FRAME_WIDTH - `PLAYER_W) / 2);
    localparam videoPkg::pixelT PLAYER_MIN = videoPkg::pixelT'(1); // just inside the border
    localparam videoPkg::pixelT PLAYER_MAX = videoPkg::pixelT'(`FRAME_WIDTH - 1 - `PLAYER_W);
    localparam videoPkg::pixelT PLAYER_MOVE = videoPkg::pixelT'(`PLAYER_STEP);
    localparam videoPkg::pixelT PLAYER_WIDTH = videoPkg::pixelT'(`PLAYER_W);
    localparam videoPkg::pixelT PLAYER_CENTRE = videoPkg::pixelT'(`PLAYER_W / 2);
    localparam videoPkg::pixelT PLAYER_TOP = videoPkg::pixelT'(`PLAYER_Y);
    localparam videoPkg::pixelT PLAYER_BOTTOM = videoPkg::pixelT'(`PLAYER_Y + `PLAYER_H);
    localparam videoPkg::pixelT MISSILE_START = videoPkg::pixelT'(`PLAYER_Y - `MISSILE_H);
    localparam videoPkg::pixelT MISSILE_MOVE = videoPkg::pixelT'(`MISSILE_STEP);
    localparam videoPkg::pixelT MISSILE_HEIGHT = videoPkg::pixelT'(`MISSILE_H);
    localparam videoPkg::pixelT MONSTER_MOVE = videoPkg::pixelT'(`MONSTER_STEP);
    localparam videoPkg::pixelT MONSTER_WIDTH = videoPkg::pixelT'(`MONSTER_W);
    localparam videoPkg::pixelT MONSTER_SPACING = videoPkg::pixelT'(`MONSTER_PITCH);
    localparam videoPkg::pixelT MONSTER_NUM = videoPkg::pixelT'(`MONSTER_COUNT);
    localparam videoPkg::pixelT MONSTER_TOP = videoPkg::pixelT'(`MONSTER_Y);
    localparam videoPkg::pixelT MONSTER_BOTTOM = videoPkg::pixelT'(`MONSTER_Y + `MONSTER_H);
    localparam videoPkg::pixelT ROW_MIN = videoPkg::pixelT'(1);
    // largest offset that keeps the last monster at or left of column FRAME_WIDTH-2
    localparam videoPkg::pixelT ROW_MAX = videoPkg::pixelT'(`FRAME_WIDTH - 1
        - (`MONSTER_COUNT - 1) * `MONSTER_PITCH - `MONSTER_W);

    videoPkg::pixelT playerX;
    logic missileActive;
    videoPkg::pixelT missileX;
    videoPkg::pixelT missileY; // top pixel
    gamePkg::monsterMaskT monsterAlive;
    videoPkg::pixelT monsterOffset; // left edge of monster 0
    logic monsterRight;
    videoPkg::pixelT monsterRelX;
    videoPkg::pixelT monsterColumn;
    logic [`MONSTER_INDEX_WIDTH - 1:0] monsterIndex;

    always_ff @(posedge clk) begin
        if (reset) begin
            playerX <= PLAYER_START;
        end else if (lastPixel && (leftHeld != rightHeld)) begin
            if (leftHeld) begin
                playerX <= (playerX < PLAYER_MIN + PLAYER_MOVE) ? PLAYER_MIN : playerX - PLAYER_MOVE;
            end else begin
                playerX <= (playerX + PLAYER_MOVE > PLAYER_MAX) ? PLAYER_MAX : playerX + PLAYER_MOVE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            missileActive <= 1'b0;
        end else if (lastPixel) begin
            if (missileActive) begin
                if ((hitMask != '0) || (missileY < ROW_MIN + MISSILE_MOVE)) begin
                    missileActive <= 1'b0;
                end else begin
                    missileY <= missileY - MISSILE_MOVE;
                end
            end else if (fireHeld) begin
                missileActive <= 1'b1;
                missileX <= playerX + PLAYER_CENTRE;
                missileY <= MISSILE_START; // right above the cannon
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            monsterAlive <= '1;
            monsterOffset <= ROW_MIN;
            monsterRight <= 1'b1;
            score <= '0;
        end else if (lastPixel) begin
            monsterAlive <= monsterAlive & ~hitMask;
            score <= score + gamePkg::scoreT'($countones(hitMask));
            if (monsterRight) begin
                if (monsterOffset + MONSTER_MOVE > ROW_MAX) begin
                    monsterRight <= 1'b0; // bounce instead of stepping
                end else begin
                    monsterOffset <= monsterOffset + MONSTER_MOVE;
                end
            end else if (monsterOffset < ROW_MIN + MONSTER_MOVE) begin
                monsterRight <= 1'b1;
            end else begin
                monsterOffset <= monsterOffset - MONSTER_MOVE;
            end
        end
    end

    assign monsterRelX = scanX - monsterOffset;
    assign monsterColumn = monsterRelX / MONSTER_SPACING;
    assign monsterIndex = monsterColumn[`MONSTER_INDEX_WIDTH - 1:0];

    assign obj.playerDraw = (scanX >= playerX) && (scanX < playerX + PLAYER_WIDTH)
        && (scanY >= PLAYER_TOP) && (scanY < PLAYER_BOTTOM);
    assign obj.missileDraw = missileActive && (scanX == missileX)
        && (scanY >= missileY) && (scanY < missileY + MISSILE_HEIGHT);
    assign obj.monsterDraw = (scanX >= monsterOffset) && (monsterColumn < MONSTER_NUM)
        && (monsterRelX % MONSTER_SPACING < MONSTER_WIDTH)
        && (scanY >= MONSTER_TOP) && (scanY < MONSTER_BOTTOM) && monsterAlive[monsterIndex];
    assign obj.monsterIndex = monsterIndex;

    assign obj.playerRgb = videoPkg::rgbT'(`COLOR_PLAYER);
    assign obj.missileRgb = videoPkg::rgbT'(`COLOR_MISSILE);
    assign obj.monsterRgb = videoPkg::rgbT'(`COLOR_MONSTER);

endmodule

// ==== design/videoUnit.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module videoUnit (
    input logic clk,
    input logic reset,
    drawIf.mixer obj,
    output videoPkg::pixelT scanX,
    output videoPkg::pixelT scanY,
    output logic lastPixel,
    output videoPkg::pixelT pixelX,
    output videoPkg::pixelT pixelY,
    output logic frameStart,
    output videoPkg::rgbT rgb
);

    localparam videoPkg::pixelT LAST_X = videoPkg::pixelT'(`FRAME_WIDTH - 1);
    localparam videoPkg::pixelT LAST_Y = videoPkg::pixelT'(`FRAME_HEIGHT - 1);
    localparam videoPkg::pixelT ONE = videoPkg::pixelT'(1);
    localparam videoPkg::rgbT BORDER = videoPkg::rgbT'(`COLOR_BORDER);
    localparam videoPkg::rgbT BACKGROUND = videoPkg::rgbT'(`COLOR_BACKGROUND);

    logic rowEnd;
    logic border;
    videoPkg::rgbT pixelColour;

    assign rowEnd = (scanX == LAST_X);
    assign lastPixel = rowEnd && (scanY == LAST_Y);
    assign border = (scanX == '0) || rowEnd || (scanY == '0) || (scanY == LAST_Y);

    always_ff @(posedge clk) begin
        if (reset) begin
            scanX <= '0;
            scanY <= '0;
        end else if (rowEnd) begin
            scanX <= '0;
            scanY <= lastPixel ? '0 : scanY + ONE;
        end else begin
            scanX <= scanX + ONE;
        end
    end

    // fixed priority, border sits under every object
    always_comb begin
        if (obj.playerDraw) begin
            pixelColour = obj.playerRgb;
        end else if (obj.missileDraw) begin
            pixelColour = obj.missileRgb;
        end else if (obj.monsterDraw) begin
            pixelColour = obj.monsterRgb;
        end else if (border) begin
            pixelColour = BORDER;
        end else begin
            pixelColour = BACKGROUND;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pixelX <= '0;
            pixelY <= '0;
            frameStart <= 1'b0;
            rgb <= BACKGROUND;
        end else begin
            pixelX <= scanX;
            pixelY <= scanY;
            frameStart <= (scanX == '0) && (scanY == '0);
            rgb <= pixelColour;
        end
    end

    rasterInFrame: assert property (@(posedge clk) disable iff (reset)
        (scanX < `FRAME_WIDTH) && (scanY < `FRAME_HEIGHT))
        else $error("raster counter outside the playfield");

endmodule

// ==== design/invadersTop.sv ====
`timescale 1ns/1ps

module invadersTop (
    input logic clk,
    input logic reset,
    input logic scanValid,
    input gamePkg::scanByteT scanByte,

    output videoPkg::pixelT pixelX,
    output videoPkg::pixelT pixelY,
    output logic frameStart,
    output videoPkg::rgbT rgb,
    output gamePkg::scoreT score
);

    logic leftHeld;
    logic rightHeld;
    logic fireHeld;
    logic lastPixel;
    videoPkg::pixelT scanX; // raster position before the output register
    videoPkg::pixelT scanY;
    gamePkg::monsterMaskT hitMask;

    drawIf drawBus ();

    scanDecoder decoderInst (
        .clk       (clk),
        .reset     (reset),
        .scanValid (scanValid),
        .scanByte  (scanByte),
        .leftHeld  (leftHeld),
        .rightHeld (rightHeld),
        .fireHeld  (fireHeld));

    gameObjects objectsInst (
        .clk       (clk),
        .reset     (reset),
        .leftHeld  (leftHeld),
        .rightHeld (rightHeld),
        .fireHeld  (fireHeld),
        .lastPixel (lastPixel),
        .scanX     (scanX),
        .scanY     (scanY),
        .hitMask   (hitMask),
        .obj       (drawBus.object),
        .score     (score));

    hitDetector hitInst (
        .clk       (clk),
        .reset     (reset),
        .lastPixel (lastPixel),
        .obj       (drawBus.mixer),
        .hitMask   (hitMask));

    videoUnit videoInst (
        .clk        (clk),
        .reset      (reset),
        .obj        (drawBus.mixer),
        .scanX      (scanX),
        .scanY      (scanY),
        .lastPixel  (lastPixel),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .frameStart (frameStart),
        .rgb        (rgb));

endmodule

// ==== verification/tbChecker.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module tbChecker (
    input logic clk,
    input logic reset,
    input logic scanValid,
    input gamePkg::scanByteT scanByte,
    input videoPkg::pixelT pixelX,
    input videoPkg::pixelT pixelY,
    input logic frameStart,
    input videoPkg::rgbT rgb,
    input gamePkg::scoreT score,
    output int frameCount,
    output int errorCount
);

    logic resetQ; // reset as the DUT saw it on the last edge
    logic pendingValid; // byte the DUT took on the last edge
    gamePkg::scanByteT pendingByte;
    logic extSeen;
    logic breakSeen;
    logic leftKey;
    logic rightKey;
    logic fireKey;
    int expX;
    int expY;
    int playerX;
    int missileX;
    int missileY;
    int rowOffset;
    int expScore;
    logic missileOn;
    logic rowRight;
    logic [`MONSTER_COUNT - 1:0] alive;
    logic [`MONSTER_COUNT - 1:0] hits;

    initial begin
        frameCount = 0;
        errorCount = 0;
    end

    always @(posedge clk) resetQ <= reset;

    task automatic reportValue(input string name, input int got, input int want);
        errorCount++;
        $display("FAIL %s: got %h, expected %h at pixel (%0d,%0d)", name, got, want, expX, expY);
    endtask

    function automatic int monsterAt(input int x, input int y);
        int left;
        monsterAt = -1;
        for (int i = 0; i < `MONSTER_COUNT; i++) begin
            left = rowOffset + i * `MONSTER_PITCH;
            if (alive[i] && x >= left && x < left + `MONSTER_W
                && y >= `MONSTER_Y && y < `MONSTER_Y + `MONSTER_H) monsterAt = i;
        end
    endfunction

    // E0 and F0 prefixes, then the code ends the sequence
    task automatic decodeByte(input gamePkg::scanByteT value);
        if (value == `SC_EXTEND && !extSeen && !breakSeen) begin
            extSeen = 1'b1;
        end else if (value == `SC_BREAK && !breakSeen) begin
            breakSeen = 1'b1;
        end else begin
            if (extSeen && value == `SC_LEFT) leftKey = !breakSeen;
            if (extSeen && value == `SC_RIGHT) rightKey = !breakSeen;
            if (!extSeen && value == `SC_FIRE) fireKey = !breakSeen;
            extSeen = 1'b0;
            breakSeen = 1'b0;
        end
    endtask

    task automatic updateFrame();
        int lastColumn;
        if (missileOn) begin
            if (hits != '0 || missileY - `MISSILE_STEP < 1) begin
                missileOn = 1'b0;
            end else begin
                missileY = missileY - `MISSILE_STEP;
            end
        end else if (fireKey) begin
            missileOn = 1'b1; // launched from where the cannon was this frame
            missileX = playerX + `PLAYER_W / 2;
            missileY = `PLAYER_Y - `MISSILE_H;
        end
        if (leftKey && !rightKey) playerX = (playerX - `PLAYER_STEP < 1) ? 1 : playerX - `PLAYER_STEP;
        if (rightKey && !leftKey) begin
            playerX = playerX + `PLAYER_STEP;
            if (playerX + `PLAYER_W > `FRAME_WIDTH - 1) playerX = `FRAME_WIDTH - 1 - `PLAYER_W;
        end
        expScore = (expScore + $countones(hits)) % 256;
        alive = alive & ~hits;
        hits = '0;
        if (rowRight) begin
            lastColumn = rowOffset + `MONSTER_STEP + (`MONSTER_COUNT - 1) * `MONSTER_PITCH
                + `MONSTER_W - 1;
            if (lastColumn > `FRAME_WIDTH - 2) rowRight = 1'b0;
            else rowOffset = rowOffset + `MONSTER_STEP;
        end else if (rowOffset - `MONSTER_STEP < 1) begin
            rowRight = 1'b1;
        end else begin
            rowOffset = rowOffset - `MONSTER_STEP;
        end
    endtask

    always @(negedge clk) begin : compareStep
        int monster;
        logic playerHere;
        logic missileHere;
        logic [7:0] expRgb;
        if (resetQ) begin
            expX = 0;
            expY = 0;
            playerX = (`FRAME_WIDTH - `PLAYER_W) / 2;
            missileOn = 1'b0;
            alive = '1;
            hits = '0;
            rowOffset = 1;
            rowRight = 1'b1;
            expScore = 0;
            {extSeen, breakSeen, leftKey, rightKey, fireKey} = '0;
            pendingValid = 1'b0;
            if (score != '0) reportValue("score", int'(score), 0);
            if (rgb != `COLOR_BACKGROUND) reportValue("rgb", int'(rgb), `COLOR_BACKGROUND);
            if (frameStart) reportValue("frameStart", 1, 0);
        end else begin
            if (int'(pixelX) != expX) reportValue("pixelX", int'(pixelX), expX);
            if (int'(pixelY) != expY) reportValue("pixelY", int'(pixelY), expY);
            if (frameStart != (expX == 0 && expY == 0)) begin
                reportValue("frameStart", int'(frameStart), int'(expX == 0 && expY == 0));
            end
            playerHere = expX >= playerX && expX < playerX + `PLAYER_W
                && expY >= `PLAYER_Y && expY < `PLAYER_Y + `PLAYER_H;
            missileHere = missileOn && expX == missileX && expY >= missileY
                && expY < missileY + `MISSILE_H;
            monster = monsterAt(expX, expY);
            if (missileHere && monster >= 0) hits[monster] = 1'b1;
            if (playerHere) expRgb = `COLOR_PLAYER;
            else if (missileHere) expRgb = `COLOR_MISSILE;
            else if (monster >= 0) expRgb = `COLOR_MONSTER;
            else if (expX == 0 || expY == 0 || expX == `FRAME_WIDTH - 1
                || expY == `FRAME_HEIGHT - 1) expRgb = `COLOR_BORDER;
            else expRgb = `COLOR_BACKGROUND;
            if (rgb != expRgb) reportValue("rgb", int'(rgb), int'(expRgb));
            if (expX == `FRAME_WIDTH - 1 && expY == `FRAME_HEIGHT - 1) begin
                updateFrame(); // same edge as the DUT state update
                frameCount++;
            end
            if (int'(score) != expScore) reportValue("score", int'(score), expScore);
            if (pendingValid) decodeByte(pendingByte);
            expX = (expX + 1) % `FRAME_WIDTH;
            if (expX == 0) expY = (expY + 1) % `FRAME_HEIGHT;
        end
        pendingValid = scanValid;
        pendingByte = scanByte;
    end

endmodule

// ==== verification/tbTop.sv ====
`timescale 1ns/1ps
`include "invaders_macros.svh"

module tbTop;

    localparam int RUN_FRAMES = 60;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = `FRAME_WIDTH * `FRAME_HEIGHT;
    localparam int TIMEOUT_CYCLES = 62 * FRAME_CYCLES + RESET_CYCLES; // two spare frames

    logic clk;
    logic reset;
    logic scanValid;
    gamePkg::scanByteT scanByte;
    videoPkg::pixelT pixelX;
    videoPkg::pixelT pixelY;
    logic frameStart;
    videoPkg::rgbT rgb;
    gamePkg::scoreT score;
    int frameCount;
    int errorCount;
    int cycleCount;
    int seed;

    invadersTop i_dut (
        .clk        (clk),
        .reset      (reset),
        .scanValid  (scanValid),
        .scanByte   (scanByte),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .frameStart (frameStart),
        .rgb        (rgb),
        .score      (score));

    tbChecker pixelCheck (
        .clk        (clk),
        .reset      (reset),
        .scanValid  (scanValid),
        .scanByte   (scanByte),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .frameStart (frameStart),
        .rgb        (rgb),
        .score      (score),
        .frameCount (frameCount),
        .errorCount (errorCount));

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d frames done", cycleCount, frameCount);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // map prefixes and the fire key onto another unused code
    function automatic gamePkg::scanByteT unknownCode(input gamePkg::scanByteT raw);
        if (raw == `SC_EXTEND || raw == `SC_BREAK || raw == `SC_FIRE) return 8'h1C;
        return raw;
    endfunction

    // one valid cycle, then a short gap inside a sequence or a long hold after it
    task automatic sendByte(input gamePkg::scanByteT value, input logic isLast);
        logic [31:0] rnd;
        int gap;
        rnd = $random(seed);
        gap = isLast ? int'(rnd[11:0]) : int'(rnd[1:0]);
        scanValid = 1'b1;
        scanByte = value;
        @(posedge clk);
        #1;
        scanValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendKey(input logic extended, input logic isBreak, input gamePkg::scanByteT code);
        if (extended) sendByte(`SC_EXTEND, 1'b0);
        if (isBreak) sendByte(`SC_BREAK, 1'b0);
        sendByte(code, 1'b1);
    endtask

    task automatic sendEvent();
        logic [31:0] pick;
        pick = $random(seed);
        case (pick[2:0])
            3'd0, 3'd1: sendKey(1'b1, pick[0], `SC_LEFT); // bit 0 picks press or release
            3'd2, 3'd3: sendKey(1'b1, pick[0], `SC_RIGHT);
            3'd4, 3'd5: sendKey(1'b0, pick[0], `SC_FIRE);
            default: sendKey(1'b0, pick[0], unknownCode(pick[15:8]));
        endcase
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        scanValid = 1'b0;
        scanByte = '0;
        cycleCount = 0;
        seed = 32'h7933_1930;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        while (frameCount < RUN_FRAMES) begin
            sendEvent();
        end
        @(posedge clk);
        $display("%0d frames checked, %0d errors", frameCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/videoPkg.sv
design/gamePkg.sv
design/drawIf.sv
design/scanDecoder.sv
design/hitDetector.sv
design/gameObjects.sv
design/videoUnit.sv
design/invadersTop.sv
verification/tbChecker.sv
verification/tbTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbTop -f compile.f

./obj_dir/VtbTop | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
